// ==== hw/rv_front_params.svh ====
`ifndef RV_FRONT_PARAMS_SVH
`define RV_FRONT_PARAMS_SVH

// first fetch address
`define RESET_PC 32'h8000_0000

// fetch queue entries, power of two
`define QUEUE_DEPTH 4

`define XLEN 32

`endif

// ==== hw/rv_front_pkg.sv ====
`include "rv_front_params.svh"

package rv_front_pkg;

    // opcode/funct view of an instruction word
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_fields_t;

    // slices the immediate formats are assembled from
    typedef struct packed {
        logic       sign;      // bit 31
        logic [5:0] hi_30_25;
        logic [3:0] hi_24_21;
        logic       bit_20;
        logic [7:0] mid_19_12;
        logic [3:0] lo_11_8;
        logic       bit_7;
        logic [6:0] op;
    } inst_imm_t;

    typedef union packed {
        inst_fields_t fields;
        inst_imm_t    imm;
    } inst_u;

    typedef struct packed {
        logic [`XLEN-1:0] pc;
        inst_u            inst;
        logic             fault; // bus error on fetch
    } fetch_entry_t;

    typedef struct packed {
        logic [3:0]       alu_func;
        logic             alu_a_sel;
        logic             alu_b_sel;
        logic             w_en;
        logic [1:0]       w_sel;
        logic [2:0]       branch_type;
        logic             jump;
        logic             mem_rd_en;
        logic             mem_wr_en;
        logic [2:0]       mem_rd_ctrl;
        logic [7:0]       mem_wr_ctrl;
        logic             is_jal;
        logic             is_jalr;
        logic             illegal;
        logic [`XLEN-1:0] imm;
        logic [`XLEN-1:0] pc;
    } decoded_t;

    // write-back source
    localparam logic [1:0] W_SEL_NONE = 2'd0;
    localparam logic [1:0] W_SEL_PC4  = 2'd1;
    localparam logic [1:0] W_SEL_ALU  = 2'd2;
    localparam logic [1:0] W_SEL_MEM  = 2'd3;

    localparam logic [2:0] BR_NONE = 3'd0;
    localparam logic [2:0] BR_EQ   = 3'd1;
    localparam logic [2:0] BR_NE   = 3'd2;
    localparam logic [2:0] BR_LT   = 3'd3;
    localparam logic [2:0] BR_GE   = 3'd4;
    localparam logic [2:0] BR_LTU  = 3'd5;
    localparam logic [2:0] BR_GEU  = 3'd6;

    localparam logic [3:0] ALU_ADD  = 4'd0;
    localparam logic [3:0] ALU_SLL  = 4'd1;
    localparam logic [3:0] ALU_SLT  = 4'd2;
    localparam logic [3:0] ALU_SLTU = 4'd3;
    localparam logic [3:0] ALU_XOR  = 4'd4;
    localparam logic [3:0] ALU_SRL  = 4'd5;
    localparam logic [3:0] ALU_OR   = 4'd6;
    localparam logic [3:0] ALU_AND  = 4'd7;
    localparam logic [3:0] ALU_SUB  = 4'd8;
    localparam logic [3:0] ALU_SRA  = 4'd13;
    localparam logic [3:0] ALU_LUI  = 4'd14;

    localparam logic [2:0] MEM_RD_NONE = 3'd0;
    localparam logic [2:0] MEM_RD_LB   = 3'd1;
    localparam logic [2:0] MEM_RD_LBU  = 3'd2;
    localparam logic [2:0] MEM_RD_LH   = 3'd3;
    localparam logic [2:0] MEM_RD_LHU  = 3'd4;
    localparam logic [2:0] MEM_RD_LW   = 3'd5;

    localparam logic [7:0] MEM_WR_NONE = 8'd0;
    localparam logic [7:0] MEM_WR_SB   = 8'd1;
    localparam logic [7:0] MEM_WR_SH   = 8'd2;
    localparam logic [7:0] MEM_WR_SW   = 8'd3;

    localparam logic [6:0] OP_LUI    = 7'h37;
    localparam logic [6:0] OP_AUIPC  = 7'h17;
    localparam logic [6:0] OP_JAL    = 7'h6f;
    localparam logic [6:0] OP_JALR   = 7'h67;
    localparam logic [6:0] OP_BRANCH = 7'h63;
    localparam logic [6:0] OP_LOAD   = 7'h03;
    localparam logic [6:0] OP_STORE  = 7'h23;
    localparam logic [6:0] OP_IMM    = 7'h13;
    localparam logic [6:0] OP_REG    = 7'h33;

endpackage

// ==== hw/inst_stream_if.sv ====
`timescale 1ns/1ps

// fetched entries moving with valid/ready
interface inst_stream_if;

    logic                       valid;
    logic                       ready;
    rv_front_pkg::fetch_entry_t entry;

    modport src (
        output valid,
        output entry,
        input  ready
    );

    modport dst (
        input  valid,
        input  entry,
        output ready
    );

endinterface

// ==== hw/fetch_unit.sv ====
`timescale 1ns/1ps
`include "rv_front_params.svh"

module fetch_unit (
    input  logic               clk,
    input  logic               arst_n,
    output logic [`XLEN-1:0]   araddr,
    output logic [2:0]         arprot,
    output logic               arvalid,
    input  logic               arready,
    input  logic [`XLEN-1:0]   rdata,
    input  logic [1:0]         rresp,
    input  logic               rvalid,
    output logic               rready,
    inst_stream_if.src         push
);

    typedef enum logic [1:0] {
        S_ADDR,
        S_DATA,
        S_PUSH
    } state_t;

    state_t                     state;
    logic [`XLEN-1:0]           pc;
    logic                       push_valid;
    rv_front_pkg::fetch_entry_t entry;

    assign araddr     = pc;     // pc only moves outside S_ADDR
    assign arprot     = 3'b100; // instruction, secure, unprivileged
    assign push.valid = push_valid;
    assign push.entry = entry;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= S_ADDR;
            pc         <= `RESET_PC;
            arvalid    <= 1'b0;
            rready     <= 1'b0;
            push_valid <= 1'b0;
        end else begin
            case (state)
                S_ADDR: begin
                    if (!arvalid) begin
                        arvalid <= 1'b1;
                    end else if (arready) begin
                        arvalid <= 1'b0;
                        rready  <= 1'b1;
                        state   <= S_DATA;
                    end
                end
                S_DATA: begin
                    if (rvalid) begin
                        rready     <= 1'b0;
                        push_valid <= 1'b1;
                        state      <= S_PUSH;
                    end
                end
                S_PUSH: begin
                    // a full queue holds us here, so no new AR goes out
                    if (push.ready) begin
                        push_valid <= 1'b0;
                        pc         <= pc + 4;
                        state      <= S_ADDR;
                    end
                end
                default: state <= S_ADDR;
            endcase
        end
    end

    // capture the R beat
    always_ff @(posedge clk) begin
        if (rvalid && rready) begin
            entry.pc    <= pc;
            entry.inst  <= rdata;
            entry.fault <= |rresp; // SLVERR or DECERR
        end
    end

endmodule

// ==== hw/inst_queue.sv ====
`timescale 1ns/1ps
`include "rv_front_params.svh"

module inst_queue (
    input  logic       clk,
    input  logic       arst_n,
    inst_stream_if.dst wr,
    inst_stream_if.src rd
);

    localparam int PTR_W = $clog2(`QUEUE_DEPTH);
    localparam logic [PTR_W:0] DEPTH = `QUEUE_DEPTH;

    rv_front_pkg::fetch_entry_t mem [`QUEUE_DEPTH];
    logic [PTR_W-1:0]           wr_ptr;
    logic [PTR_W-1:0]           rd_ptr;
    logic [PTR_W:0]             count;
    logic                       push;
    logic                       pop;

    assign rd.valid = (count != '0);
    assign rd.entry = mem[rd_ptr];

    // full queue still takes a word when the head leaves this cycle
    assign wr.ready = (count != DEPTH) || rd.ready;

    assign push = wr.valid && wr.ready;
    assign pop  = rd.valid && rd.ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1; // wraps, depth is a power of two
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr.entry;
        end
    end

endmodule

// ==== hw/inst_decoder.sv ====
`timescale 1ns/1ps

module inst_decoder (
    input  logic                   clk,
    input  logic                   arst_n,
    inst_stream_if.dst             in,
    output logic                   out_valid,
    input  logic                   out_ready,
    output rv_front_pkg::decoded_t out
);

    rv_front_pkg::inst_fields_t fv;
    rv_front_pkg::inst_imm_t    iv;
    rv_front_pkg::decoded_t     dec;

    assign fv = in.entry.inst.fields;
    assign iv = in.entry.inst.imm;

    // a faulted word gets an opcode that matches nothing
    wire [6:0] opcode = in.entry.fault ? 7'h00 : fv.opcode;
    wire [2:0] f3     = fv.funct3;
    wire [6:0] f7     = fv.funct7;

    wire op_branch = (opcode == rv_front_pkg::OP_BRANCH);
    wire op_load   = (opcode == rv_front_pkg::OP_LOAD);
    wire op_store  = (opcode == rv_front_pkg::OP_STORE);
    wire op_imm    = (opcode == rv_front_pkg::OP_IMM);
    wire op_reg    = (opcode == rv_front_pkg::OP_REG);

    wire is_lui   = (opcode == rv_front_pkg::OP_LUI);
    wire is_auipc = (opcode == rv_front_pkg::OP_AUIPC);
    wire is_jal   = (opcode == rv_front_pkg::OP_JAL);
    wire is_jalr  = (opcode == rv_front_pkg::OP_JALR) && (f3 == 3'h0);
    wire is_beq   = op_branch && (f3 == 3'h0);
    wire is_bne   = op_branch && (f3 == 3'h1);
    wire is_blt   = op_branch && (f3 == 3'h4);
    wire is_bge   = op_branch && (f3 == 3'h5);
    wire is_bltu  = op_branch && (f3 == 3'h6);
    wire is_bgeu  = op_branch && (f3 == 3'h7);
    wire is_lb    = op_load && (f3 == 3'h0);
    wire is_lh    = op_load && (f3 == 3'h1);
    wire is_lw    = op_load && (f3 == 3'h2);
    wire is_lbu   = op_load && (f3 == 3'h4);
    wire is_lhu   = op_load && (f3 == 3'h5);
    wire is_sb    = op_store && (f3 == 3'h0);
    wire is_sh    = op_store && (f3 == 3'h1);
    wire is_sw    = op_store && (f3 == 3'h2);
    wire is_addi  = op_imm && (f3 == 3'h0);
    wire is_slti  = op_imm && (f3 == 3'h2);
    wire is_sltiu = op_imm && (f3 == 3'h3);
    wire is_xori  = op_imm && (f3 == 3'h4);
    wire is_ori   = op_imm && (f3 == 3'h6);
    wire is_andi  = op_imm && (f3 == 3'h7);
    wire is_slli  = op_imm && (f3 == 3'h1) && (f7 == 7'h00);
    wire is_srli  = op_imm && (f3 == 3'h5) && (f7 == 7'h00);
    wire is_srai  = op_imm && (f3 == 3'h5) && (f7 == 7'h20);
    wire is_add   = op_reg && (f3 == 3'h0) && (f7 == 7'h00);
    wire is_sub   = op_reg && (f3 == 3'h0) && (f7 == 7'h20);
    wire is_sll   = op_reg && (f3 == 3'h1) && (f7 == 7'h00);
    wire is_slt   = op_reg && (f3 == 3'h2) && (f7 == 7'h00);
    wire is_sltu  = op_reg && (f3 == 3'h3) && (f7 == 7'h00);
    wire is_xor   = op_reg && (f3 == 3'h4) && (f7 == 7'h00);
    wire is_srl   = op_reg && (f3 == 3'h5) && (f7 == 7'h00);
    wire is_sra   = op_reg && (f3 == 3'h5) && (f7 == 7'h20);
    wire is_or    = op_reg && (f3 == 3'h6) && (f7 == 7'h00);
    wire is_and   = op_reg && (f3 == 3'h7) && (f7 == 7'h00);

    // format groups
    wire grp_u    = is_lui | is_auipc;
    wire grp_b    = is_beq | is_bne | is_blt | is_bge | is_bltu | is_bgeu;
    wire grp_load = is_lb | is_lh | is_lw | is_lbu | is_lhu;
    wire grp_s    = is_sb | is_sh | is_sw;
    wire grp_aimm = is_addi | is_slti | is_sltiu | is_xori | is_ori | is_andi
                  | is_slli | is_srli | is_srai;
    wire grp_i    = is_jalr | grp_load | grp_aimm;
    wire grp_r    = is_add | is_sub | is_sll | is_slt | is_sltu | is_xor
                  | is_srl | is_sra | is_or | is_and;

    always_comb begin
        dec.alu_a_sel = grp_s | grp_i | grp_r; // rs1, else pc
        dec.alu_b_sel = !grp_r;                // imm, else rs2
        dec.w_en      = grp_u | is_jal | grp_i | grp_r;
        dec.jump      = is_jal | is_jalr;
        dec.mem_rd_en = grp_load;
        dec.mem_wr_en = grp_s;
        dec.is_jal    = is_jal;
        dec.is_jalr   = is_jalr;
        dec.illegal   = !(grp_u | is_jal | grp_i | grp_s | grp_b | grp_r);
        dec.pc        = in.entry.pc;

        if (is_jal || is_jalr) dec.w_sel = rv_front_pkg::W_SEL_PC4;
        else if (grp_aimm || grp_r || grp_u) dec.w_sel = rv_front_pkg::W_SEL_ALU;
        else if (grp_load) dec.w_sel = rv_front_pkg::W_SEL_MEM;
        else dec.w_sel = rv_front_pkg::W_SEL_NONE;

        if (is_beq) dec.branch_type = rv_front_pkg::BR_EQ;
        else if (is_bne) dec.branch_type = rv_front_pkg::BR_NE;
        else if (is_blt) dec.branch_type = rv_front_pkg::BR_LT;
        else if (is_bge) dec.branch_type = rv_front_pkg::BR_GE;
        else if (is_bltu) dec.branch_type = rv_front_pkg::BR_LTU;
        else if (is_bgeu) dec.branch_type = rv_front_pkg::BR_GEU;
        else dec.branch_type = rv_front_pkg::BR_NONE;

        // address math and add/addi all fall through to add
        if (is_sub) dec.alu_func = rv_front_pkg::ALU_SUB;
        else if (is_sll || is_slli) dec.alu_func = rv_front_pkg::ALU_SLL;
        else if (is_srl || is_srli) dec.alu_func = rv_front_pkg::ALU_SRL;
        else if (is_sra || is_srai) dec.alu_func = rv_front_pkg::ALU_SRA;
        else if (is_slt || is_slti) dec.alu_func = rv_front_pkg::ALU_SLT;
        else if (is_sltu || is_sltiu) dec.alu_func = rv_front_pkg::ALU_SLTU;
        else if (is_xor || is_xori) dec.alu_func = rv_front_pkg::ALU_XOR;
        else if (is_or || is_ori) dec.alu_func = rv_front_pkg::ALU_OR;
        else if (is_and || is_andi) dec.alu_func = rv_front_pkg::ALU_AND;
        else if (is_lui) dec.alu_func = rv_front_pkg::ALU_LUI;
        else dec.alu_func = rv_front_pkg::ALU_ADD;

        if (is_lb) dec.mem_rd_ctrl = rv_front_pkg::MEM_RD_LB;
        else if (is_lbu) dec.mem_rd_ctrl = rv_front_pkg::MEM_RD_LBU;
        else if (is_lh) dec.mem_rd_ctrl = rv_front_pkg::MEM_RD_LH;
        else if (is_lhu) dec.mem_rd_ctrl = rv_front_pkg::MEM_RD_LHU;
        else if (is_lw) dec.mem_rd_ctrl = rv_front_pkg::MEM_RD_LW;
        else dec.mem_rd_ctrl = rv_front_pkg::MEM_RD_NONE;

        if (is_sb) dec.mem_wr_ctrl = rv_front_pkg::MEM_WR_SB;
        else if (is_sh) dec.mem_wr_ctrl = rv_front_pkg::MEM_WR_SH;
        else if (is_sw) dec.mem_wr_ctrl = rv_front_pkg::MEM_WR_SW;
        else dec.mem_wr_ctrl = rv_front_pkg::MEM_WR_NONE;

        // sign-extended immediate per format, zero for R type
        if (grp_i) begin
            dec.imm = {{21{iv.sign}}, iv.hi_30_25, iv.hi_24_21, iv.bit_20};
        end else if (grp_s) begin
            dec.imm = {{21{iv.sign}}, iv.hi_30_25, iv.lo_11_8, iv.bit_7};
        end else if (grp_b) begin
            dec.imm = {{20{iv.sign}}, iv.bit_7, iv.hi_30_25, iv.lo_11_8, 1'b0};
        end else if (grp_u) begin
            dec.imm = {iv.sign, iv.hi_30_25, iv.hi_24_21, iv.bit_20, iv.mid_19_12, 12'h000};
        end else if (is_jal) begin
            dec.imm = {{12{iv.sign}}, iv.mid_19_12, iv.bit_20, iv.hi_30_25, iv.hi_24_21, 1'b0};
        end else begin
            dec.imm = '0;
        end
    end

    // one output register, refilled as it drains
    assign in.ready = !out_valid || out_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (in.valid && in.ready) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in.valid && in.ready) begin
            out <= dec;
        end
    end

endmodule

// ==== hw/rv_front_top.sv ====
`timescale 1ns/1ps
`include "rv_front_params.svh"

module rv_front_top (
    input  logic             clk,
    input  logic             arst_n,
    // AXI4-Lite read master
    output logic [`XLEN-1:0] araddr,
    output logic [2:0]       arprot,
    output logic             arvalid,
    input  logic             arready,
    input  logic [`XLEN-1:0] rdata,
    input  logic [1:0]       rresp,
    input  logic             rvalid,
    output logic             rready,
    // decoded stream
    output logic             out_valid,
    input  logic             out_ready,
    output logic [3:0]       alu_func,
    output logic             alu_a_sel,
    output logic             alu_b_sel,
    output logic             w_en,
    output logic [1:0]       w_sel,
    output logic [2:0]       branch_type,
    output logic             jump,
    output logic             mem_rd_en,
    output logic             mem_wr_en,
    output logic [2:0]       mem_rd_ctrl,
    output logic [7:0]       mem_wr_ctrl,
    output logic             is_jal,
    output logic             is_jalr,
    output logic             illegal,
    output logic [`XLEN-1:0] imm,
    output logic [`XLEN-1:0] pc
);

    rv_front_pkg::decoded_t dec;

    inst_stream_if fetch_q ();
    inst_stream_if q_dec ();

    fetch_unit u_fetch (
        .clk     (clk),
        .arst_n  (arst_n),
        .araddr  (araddr),
        .arprot  (arprot),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .push    (fetch_q.src)
    );

    inst_queue u_queue (
        .clk    (clk),
        .arst_n (arst_n),
        .wr     (fetch_q.dst),
        .rd     (q_dec.src)
    );

    inst_decoder u_dec (
        .clk       (clk),
        .arst_n    (arst_n),
        .in        (q_dec.dst),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out       (dec)
    );

    // flatten the bundle
    assign alu_func    = dec.alu_func;
    assign alu_a_sel   = dec.alu_a_sel;
    assign alu_b_sel   = dec.alu_b_sel;
    assign w_en        = dec.w_en;
    assign w_sel       = dec.w_sel;
    assign branch_type = dec.branch_type;
    assign jump        = dec.jump;
    assign mem_rd_en   = dec.mem_rd_en;
    assign mem_wr_en   = dec.mem_wr_en;
    assign mem_rd_ctrl = dec.mem_rd_ctrl;
    assign mem_wr_ctrl = dec.mem_wr_ctrl;
    assign is_jal      = dec.is_jal;
    assign is_jalr     = dec.is_jalr;
    assign illegal     = dec.illegal;
    assign imm         = dec.imm;
    assign pc          = dec.pc;

endmodule

// ==== sim/rv_front_properties.sv ====
`timescale 1ns/1ps

module rv_front_properties (
    input logic        clk,
    input logic        arst_n,
    input logic        arvalid,
    input logic        arready,
    input logic [31:0] araddr,
    input logic        rready,
    input logic        out_valid,
    input logic        out_ready,
    input logic [3:0]  alu_func,
    input logic        alu_a_sel,
    input logic        alu_b_sel,
    input logic        w_en,
    input logic [1:0]  w_sel,
    input logic [2:0]  branch_type,
    input logic        jump,
    input logic        mem_rd_en,
    input logic        mem_wr_en,
    input logic [2:0]  mem_rd_ctrl,
    input logic [7:0]  mem_wr_ctrl,
    input logic        is_jal,
    input logic        is_jalr,
    input logic        illegal,
    input logic [31:0] imm,
    input logic [31:0] pc
);

    // held AR request keeps its address
    ar_hold: assert property (@(posedge clk) disable iff (!arst_n)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else $error("arvalid dropped or araddr moved before arready");

    // stalled output keeps the bundle
    out_hold: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid
            && $stable({alu_func, alu_a_sel, alu_b_sel, w_en, w_sel, branch_type, jump})
            && $stable({mem_rd_en, mem_wr_en, mem_rd_ctrl, mem_wr_ctrl})
            && $stable({is_jal, is_jalr, illegal, imm, pc}))
        else $error("decoded output changed while out_ready was low");

    reset_idle: assert property (@(posedge clk)
        !arst_n |-> !arvalid && !rready && !out_valid)
        else $error("handshake outputs active during reset");

endmodule

// ==== sim/tb_rv_front.sv ====
`timescale 1ns/1ps
`include "rv_front_params.svh"

module tb_rv_front;

    localparam int PROG_LEN  = 42;
    localparam int FAULT_IDX = 20; // answered with SLVERR
    localparam int MAX_CYC   = 5000;

    logic        clk, arst_n, arready, rvalid, out_ready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic [31:0] araddr, imm, pc;
    logic [2:0]  arprot, branch_type, mem_rd_ctrl;
    logic        arvalid, rready, out_valid, alu_a_sel, alu_b_sel, w_en, jump;
    logic        mem_rd_en, mem_wr_en, is_jal, is_jalr, illegal;
    logic [3:0]  alu_func;
    logic [1:0]  w_sel;
    logic [7:0]  mem_wr_ctrl;

    // lui auipc jal jalr, branches, loads, stores, op-imm, op, then illegal words
    logic [31:0] prog [PROG_LEN] = '{
        32'h123450b7, 32'hfffff117, 32'hff9ff0ef, 32'h000080e7, 32'h00208463, 32'hfe209ee3,
        32'h0020c463, 32'h0020d463, 32'h0020e463, 32'h0020f463, 32'h00008083, 32'h00009083,
        32'hffc0a083, 32'h0000c083, 32'h0000d083, 32'h00208023, 32'h00209023, 32'hfe20ae23,
        32'h80008093, 32'h0010a093, 32'h00100093, 32'h0010b093, 32'hfff0c093, 32'h0010e093,
        32'h0ff0f093, 32'h00309093, 32'h0030d093, 32'h4030d093, 32'h002080b3, 32'h402080b3,
        32'h002090b3, 32'h0020a0b3, 32'h0020b0b3, 32'h0020c0b3, 32'h0020d0b3, 32'h4020d0b3,
        32'h0020e0b3, 32'h0020f0b3, 32'hffffffff, 32'h00000000, 32'h000090e7, 32'h6030d093
    };

    logic [31:0] rng, req_addr;
    logic [31:0] addr_q [$];
    logic        ar_fire, r_fire, outstanding;
    int          wait_cnt, out_count, cycles, idx;
    rv_front_pkg::decoded_t exp;

    rv_front_top u_dut (.*);

    bind rv_front_top rv_front_properties u_props (.*);

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic rv_front_pkg::decoded_t ref_decode(input logic [31:0] w, input logic flt);
        rv_front_pkg::decoded_t d;
        logic [2:0] f3;
        logic [6:0] f7;
        logic       ok;
        f3 = w[14:12];
        f7 = w[31:25];
        d = '0;
        d.alu_b_sel = 1'b1; // imm operand unless R type
        ok = 1'b1;
        case (w[6:0])
            7'h37, 7'h17: begin
                d.w_en = 1'b1;
                d.w_sel = 2'd2;
                d.alu_func = (w[6:0] == 7'h37) ? 4'd14 : 4'd0;
                d.imm = {w[31:12], 12'h000};
            end
            7'h6f: begin
                d.w_en = 1'b1;
                d.w_sel = 2'd1;
                d.jump = 1'b1;
                d.is_jal = 1'b1;
                d.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            end
            7'h67: begin
                ok = (f3 == 3'd0);
                d.w_en = 1'b1;
                d.w_sel = 2'd1;
                d.jump = 1'b1;
                d.is_jalr = 1'b1;
                d.alu_a_sel = 1'b1;
                d.imm = {{20{w[31]}}, w[31:20]};
            end
            7'h63: begin
                ok = (f3 != 3'd2) && (f3 != 3'd3);
                d.branch_type = (f3 < 3'd2) ? f3 + 3'd1 : f3 - 3'd1;
                d.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            end
            7'h03: begin
                ok = (f3 <= 3'd2) || (f3 == 3'd4) || (f3 == 3'd5);
                d.mem_rd_en = 1'b1;
                d.w_en = 1'b1;
                d.w_sel = 2'd3;
                d.alu_a_sel = 1'b1;
                case (f3)
                    3'd0: d.mem_rd_ctrl = 3'd1;
                    3'd1: d.mem_rd_ctrl = 3'd3;
                    3'd2: d.mem_rd_ctrl = 3'd5;
                    3'd4: d.mem_rd_ctrl = 3'd2;
                    default: d.mem_rd_ctrl = 3'd4;
                endcase
                d.imm = {{20{w[31]}}, w[31:20]};
            end
            7'h23: begin
                ok = (f3 <= 3'd2);
                d.mem_wr_en = 1'b1;
                d.alu_a_sel = 1'b1;
                d.mem_wr_ctrl = {5'd0, f3} + 8'd1;
                d.imm = {{20{w[31]}}, w[31:25], w[11:7]};
            end
            7'h13, 7'h33: begin
                if (w[5]) ok = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
                else if (f3 == 3'd1) ok = (f7 == 7'h00);
                else if (f3 == 3'd5) ok = (f7 == 7'h00) || (f7 == 7'h20);
                d.w_en = 1'b1;
                d.w_sel = 2'd2;
                d.alu_a_sel = 1'b1;
                d.alu_b_sel = !w[5];
                d.alu_func = {1'b0, f3};
                if (f3 == 3'd5 && f7[5]) d.alu_func = 4'd13;
                if (f3 == 3'd0 && f7[5] && w[5]) d.alu_func = 4'd8;
                d.imm = w[5] ? 32'd0 : {{20{w[31]}}, w[31:20]};
            end
            default: ok = 1'b0;
        endcase
        if (!ok || flt) begin
            d = '0;
            d.alu_b_sel = 1'b1;
            d.illegal = 1'b1;
        end
        return d;
    endfunction

    task automatic die(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic check_field(input string name, input logic [31:0] got, input logic [31:0] want);
        assert (got === want)
            else die($sformatf("[FAIL] %s got %h expected %h", name, got, want));
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        arready = 1'b0;
        rvalid = 1'b0;
        rdata = '0;
        rresp = '0;
        out_ready = 1'b0;
        rng = 32'hd89d_f3f5;
        ar_fire = 1'b0;
        r_fire = 1'b0;
        outstanding = 1'b0;
        wait_cnt = 0;
        out_count = 0;
        cycles = 0;
        repeat (3) @(posedge clk);
        @(negedge clk) arst_n = 1'b1;
        while (out_count < PROG_LEN) begin
            @(negedge clk);
            cycles++;
            if (cycles > MAX_CYC) die("timeout waiting for the decoded program");
            if (r_fire) begin
                rvalid = 1'b0;
                outstanding = 1'b0;
            end
            if (ar_fire) begin
                arready = 1'b0;
                idx = (req_addr - `RESET_PC) >> 2;
                rvalid = 1'b1;
                rdata = (idx < PROG_LEN) ? prog[idx] : 32'h0000_0013;
                rresp = (idx == FAULT_IDX) ? 2'b10 : 2'b00;
                rng = lcg_next(rng);
                wait_cnt = rng[17:16];
            end else if (arvalid && !arready) begin
                if (wait_cnt == 0) arready = 1'b1;
                else wait_cnt--;
            end
            if (arvalid && outstanding) die("new AR issued while a read is outstanding");
            ar_fire = arvalid && arready;
            r_fire = rvalid && rready;
            if (ar_fire) begin
                check_field("arprot[2]", arprot[2], 1'b1); // instruction access
                req_addr = araddr;
                addr_q.push_back(araddr);
                outstanding = 1'b1;
            end
            rng = lcg_next(rng);
            out_ready = (rng[31:30] != 2'b00); // stall about a quarter of cycles
            if (out_valid && out_ready) begin
                if (addr_q.size() == 0) die("decoded output with no matching fetch");
                exp = ref_decode(prog[out_count], out_count == FAULT_IDX);
                exp.pc = `RESET_PC + 4 * out_count;
                check_field("pc", pc, exp.pc);
                check_field("araddr", addr_q.pop_front(), exp.pc);
                check_field("alu_func", alu_func, exp.alu_func);
                check_field("alu_a_sel", alu_a_sel, exp.alu_a_sel);
                check_field("alu_b_sel", alu_b_sel, exp.alu_b_sel);
                check_field("w_en", w_en, exp.w_en);
                check_field("w_sel", w_sel, exp.w_sel);
                check_field("branch_type", branch_type, exp.branch_type);
                check_field("jump", jump, exp.jump);
                check_field("mem_rd_en", mem_rd_en, exp.mem_rd_en);
                check_field("mem_wr_en", mem_wr_en, exp.mem_wr_en);
                check_field("mem_rd_ctrl", mem_rd_ctrl, exp.mem_rd_ctrl);
                check_field("mem_wr_ctrl", mem_wr_ctrl, exp.mem_wr_ctrl);
                check_field("is_jal", is_jal, exp.is_jal);
                check_field("is_jalr", is_jalr, exp.is_jalr);
                check_field("illegal", illegal, exp.illegal);
                check_field("imm", imm, exp.imm);
                out_count++;
            end
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+hw
hw/rv_front_pkg.sv
hw/inst_stream_if.sv
hw/fetch_unit.sv
hw/inst_queue.sv
hw/inst_decoder.sv
hw/rv_front_top.sv
sim/rv_front_properties.sv
sim/tb_rv_front.sv

// ==== run_sim.sh ====
#!/bin/bash
# build and run the front-end testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f sources.f --top-module tb_rv_front \
    -o tb_rv_front > build.log 2>&1 \
    && ./obj_dir/tb_rv_front > sim.log 2>&1

cat sim.log 2>/dev/null
grep -qF "*** TEST PASSED ***" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }
